// ==== common/ooo_pkg.sv ====
// sizes of the renaming core
// widths are kept by hand next to the counts they index
// FREE_LIST_DEPTH follows from the two register counts
package ooo_pkg;

  //////////////////////////////////////////////////////////////
  // register files
  //////////////////////////////////////////////////////////////
  localparam int NUM_ARCH_REGS  = 8;
  localparam int ARCH_REG_WIDTH = 3;
  localparam int NUM_PHYS_REGS  = 16;
  localparam int PHYS_REG_WIDTH = 4;

  //////////////////////////////////////////////////////////////
  // queues
  //////////////////////////////////////////////////////////////
  // reorder buffer, power of two so the pointers wrap on their own
  localparam int ROB_DEPTH     = 8;
  localparam int ROB_IDX_WIDTH = 3;

  // reservation stations in front of the single ALU
  localparam int IQ_DEPTH = 4;

  // physical registers with no architectural owner at reset
  localparam int FREE_LIST_DEPTH = NUM_PHYS_REGS - NUM_ARCH_REGS;

endpackage

// ==== common/isa_pkg.sv ====
// instruction set of the renaming core, words arrive already decoded
// ADD, SUB and XOR wrap modulo 2^16
// LI zero-extends its 11-bit immediate
package isa_pkg;
  import ooo_pkg::*;

  localparam int DATA_WIDTH   = 16;
  localparam int OPCODE_WIDTH = 2;
  localparam int IMM_WIDTH    = DATA_WIDTH - OPCODE_WIDTH - ARCH_REG_WIDTH;
  localparam int PAD_WIDTH    = DATA_WIDTH - OPCODE_WIDTH - 3 * ARCH_REG_WIDTH;

  // opcodes
  localparam logic [OPCODE_WIDTH-1:0] OP_ADD = 2'd0;
  localparam logic [OPCODE_WIDTH-1:0] OP_SUB = 2'd1;
  localparam logic [OPCODE_WIDTH-1:0] OP_XOR = 2'd2;
  localparam logic [OPCODE_WIDTH-1:0] OP_LI  = 2'd3;

  // one word, two views; opcode and rd sit at the same bits in both
  typedef union packed {
    struct packed {
      logic [OPCODE_WIDTH-1:0]   opcode;
      logic [ARCH_REG_WIDTH-1:0] rd;
      logic [ARCH_REG_WIDTH-1:0] ra;
      logic [ARCH_REG_WIDTH-1:0] rb;
      logic [PAD_WIDTH-1:0]      pad;
    } r;
    struct packed {
      logic [OPCODE_WIDTH-1:0]   opcode;
      logic [ARCH_REG_WIDTH-1:0] rd;
      logic [IMM_WIDTH-1:0]      imm;
    } i;
  } instr_u;

endpackage

// ==== rename/free_list.sv ====
`timescale 1ns/100ps
// circular queue of free physical register numbers
// starts full with the registers above the architectural range
// push and pop may land on the same edge
module free_list
  import ooo_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      pop,
  input  logic                      push,
  input  logic [PHYS_REG_WIDTH-1:0] push_tag,
  output logic [PHYS_REG_WIDTH-1:0] head_tag,
  output logic                      empty
);

  logic [PHYS_REG_WIDTH-1:0]          slots [FREE_LIST_DEPTH];
  logic [$clog2(FREE_LIST_DEPTH)-1:0] rd_ptr;
  logic [$clog2(FREE_LIST_DEPTH)-1:0] wr_ptr;
  logic [$clog2(FREE_LIST_DEPTH):0]   count;

  assign head_tag = slots[rd_ptr];
  assign empty    = (count == '0);

  // pointers wrap by overflow, depth is a power of two
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < FREE_LIST_DEPTH; i++) begin
        slots[i] <= PHYS_REG_WIDTH'(NUM_ARCH_REGS + i);
      end
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= ($clog2(FREE_LIST_DEPTH) + 1)'(FREE_LIST_DEPTH);
    end else begin
      if (push) begin
        slots[wr_ptr] <= push_tag;
        wr_ptr        <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // rename only pops with a head, the ROB only returns what rename took
  assert property (@(posedge clock) disable iff (reset)
    !(pop && empty) && !(push && (count == FREE_LIST_DEPTH)));

endmodule

// ==== rename/rename_stage.sv ====
`timescale 1ns/100ps
// rename stage: map table, physical ready bits, free list
// dispatch_instr has to hold still while dispatch_valid waits
// LI reads no sources, both are reported ready
// no checkpoints, the map only moves forward
module rename_stage
  import ooo_pkg::*;
  import isa_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      dispatch_valid,
  input  instr_u                    dispatch_instr,
  output logic                      dispatch_ready,
  input  logic                      rob_full,
  input  logic                      iq_full,
  input  logic                      cdb_valid,
  input  logic [PHYS_REG_WIDTH-1:0] cdb_tag,
  input  logic                      free_valid,
  input  logic [PHYS_REG_WIDTH-1:0] free_tag,
  output logic                      alloc_fire,
  output logic [ARCH_REG_WIDTH-1:0] alloc_rd,
  output logic [PHYS_REG_WIDTH-1:0] alloc_new_tag,
  output logic [PHYS_REG_WIDTH-1:0] alloc_old_tag,
  output logic [OPCODE_WIDTH-1:0]   alloc_op,
  output logic [PHYS_REG_WIDTH-1:0] alloc_src_a,
  output logic [PHYS_REG_WIDTH-1:0] alloc_src_b,
  output logic                      alloc_src_a_ready,
  output logic                      alloc_src_b_ready,
  output logic [IMM_WIDTH-1:0]      alloc_imm
);

  logic [PHYS_REG_WIDTH-1:0] map_table [NUM_ARCH_REGS];
  logic [NUM_PHYS_REGS-1:0]  phys_ready;
  logic                      fl_empty;
  logic                      is_li;

  // new_tag is whatever sits at the head of the free list
  free_list free_list_inst (
    .clock    (clock),
    .reset    (reset),
    .pop      (alloc_fire),
    .push     (free_valid),
    .push_tag (free_tag),
    .head_tag (alloc_new_tag),
    .empty    (fl_empty)
  );

  //////////////////////////////////////////////////////////////
  // decode and lookup
  //////////////////////////////////////////////////////////////
  assign alloc_op  = dispatch_instr.r.opcode;
  assign alloc_rd  = dispatch_instr.r.rd;
  assign alloc_imm = dispatch_instr.i.imm;
  assign is_li     = (alloc_op == OP_LI);

  // map read before the same-edge update, so rd == ra still sees the old tag
  assign alloc_src_a   = map_table[dispatch_instr.r.ra];
  assign alloc_src_b   = map_table[dispatch_instr.r.rb];
  assign alloc_old_tag = map_table[alloc_rd];

  // ready if already marked, or broadcast on the CDB right now
  assign alloc_src_a_ready = is_li || phys_ready[alloc_src_a] ||
                             (cdb_valid && (cdb_tag == alloc_src_a));
  assign alloc_src_b_ready = is_li || phys_ready[alloc_src_b] ||
                             (cdb_valid && (cdb_tag == alloc_src_b));

  assign dispatch_ready = !fl_empty && !rob_full && !iq_full;
  assign alloc_fire     = dispatch_valid && dispatch_ready;

  // identity map at reset, every register holds a ready zero
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        map_table[i] <= PHYS_REG_WIDTH'(i);
      end
      phys_ready <= '1;
    end else begin
      if (cdb_valid) begin
        phys_ready[cdb_tag] <= 1'b1;
      end
      // popped tag is never in flight, so no clash with the CDB
      if (alloc_fire) begin
        map_table[alloc_rd]       <= alloc_new_tag;
        phys_ready[alloc_new_tag] <= 1'b0;
      end
    end
  end

endmodule

// ==== rob/reorder_buffer.sv ====
`timescale 1ns/100ps
// in-order reorder buffer, no flush
// done bits come from the CDB matching an entry's new tag
// the head result is read through the register file R port
// retiring hands old_tag back to the free list
module reorder_buffer
  import ooo_pkg::*;
  import isa_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      alloc_fire,
  input  logic [ARCH_REG_WIDTH-1:0] alloc_rd,
  input  logic [PHYS_REG_WIDTH-1:0] alloc_new_tag,
  input  logic [PHYS_REG_WIDTH-1:0] alloc_old_tag,
  input  logic                      cdb_valid,
  input  logic [PHYS_REG_WIDTH-1:0] cdb_tag,
  input  logic                      retire_ready,
  input  logic [DATA_WIDTH-1:0]     head_value,
  output logic                      rob_full,
  output logic                      retire_valid,
  output logic [ARCH_REG_WIDTH-1:0] retire_arch_reg,
  output logic [DATA_WIDTH-1:0]     retire_value,
  output logic [PHYS_REG_WIDTH-1:0] head_tag,
  output logic                      free_valid,
  output logic [PHYS_REG_WIDTH-1:0] free_tag
);

  logic [ARCH_REG_WIDTH-1:0] rd_q      [ROB_DEPTH];
  logic [PHYS_REG_WIDTH-1:0] new_tag_q [ROB_DEPTH];
  logic [PHYS_REG_WIDTH-1:0] old_tag_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0]      live;
  logic [ROB_DEPTH-1:0]      done;
  logic [ROB_IDX_WIDTH-1:0]  head;
  logic [ROB_IDX_WIDTH-1:0]  tail;
  logic [ROB_IDX_WIDTH:0]    count;
  logic                      retire_fire;

  //////////////////////////////////////////////////////////////
  // retire side
  //////////////////////////////////////////////////////////////
  assign rob_full        = (count == ROB_DEPTH);
  assign retire_valid    = live[head] && done[head];
  assign retire_fire     = retire_valid && retire_ready;
  assign retire_arch_reg = rd_q[head];
  assign head_tag        = new_tag_q[head];
  // head tag stays live until it retires, so the value holds under stall
  assign retire_value    = head_value;
  assign free_valid      = retire_fire;
  assign free_tag        = old_tag_q[head];

  // entry payload, written once at allocation
  always_ff @(posedge clock) begin
    if (alloc_fire) begin
      rd_q[tail]      <= alloc_rd;
      new_tag_q[tail] <= alloc_new_tag;
      old_tag_q[tail] <= alloc_old_tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      live  <= '0;
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      // stale entries may hold a recycled tag, only live ones complete
      for (int i = 0; i < ROB_DEPTH; i++) begin
        if (cdb_valid && live[i] && (new_tag_q[i] == cdb_tag)) begin
          done[i] <= 1'b1;
        end
      end
      if (alloc_fire) begin
        live[tail] <= 1'b1;
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1;
      end
      if (retire_fire) begin
        live[head] <= 1'b0;
        head       <= head + 1'b1;
      end
      case ({alloc_fire, retire_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // live bits and the occupancy count must agree
  assert property (@(posedge clock) disable iff (reset)
    retire_valid |-> (count != '0));

endmodule

// ==== logic/issue_queue.sv ====
`timescale 1ns/100ps
// reservation stations for the one ALU
// entry 0 is the oldest, the queue closes up behind an issued entry
// select looks at registered ready bits, so wakeup costs one cycle
module issue_queue
  import ooo_pkg::*;
  import isa_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      alloc_fire,
  input  logic [OPCODE_WIDTH-1:0]   alloc_op,
  input  logic [PHYS_REG_WIDTH-1:0] alloc_src_a,
  input  logic [PHYS_REG_WIDTH-1:0] alloc_src_b,
  input  logic                      alloc_src_a_ready,
  input  logic                      alloc_src_b_ready,
  input  logic [IMM_WIDTH-1:0]      alloc_imm,
  input  logic [PHYS_REG_WIDTH-1:0] alloc_new_tag,
  input  logic                      cdb_valid,
  input  logic [PHYS_REG_WIDTH-1:0] cdb_tag,
  output logic                      iq_full,
  output logic                      issue_valid,
  output logic [OPCODE_WIDTH-1:0]   issue_op,
  output logic [PHYS_REG_WIDTH-1:0] issue_src_a,
  output logic [PHYS_REG_WIDTH-1:0] issue_src_b,
  output logic [IMM_WIDTH-1:0]      issue_imm,
  output logic [PHYS_REG_WIDTH-1:0] issue_dest
);

  logic [IQ_DEPTH-1:0]           valid_q;
  logic [IQ_DEPTH-1:0]           rdy_a_q;
  logic [IQ_DEPTH-1:0]           rdy_b_q;
  logic [OPCODE_WIDTH-1:0]       op_q    [IQ_DEPTH];
  logic [PHYS_REG_WIDTH-1:0]     src_a_q [IQ_DEPTH];
  logic [PHYS_REG_WIDTH-1:0]     src_b_q [IQ_DEPTH];
  logic [IMM_WIDTH-1:0]          imm_q   [IQ_DEPTH];
  logic [PHYS_REG_WIDTH-1:0]     dest_q  [IQ_DEPTH];
  logic [IQ_DEPTH-1:0]           rdy_a_w;
  logic [IQ_DEPTH-1:0]           rdy_b_w;
  logic [IQ_DEPTH-1:0]           grant;
  logic [IQ_DEPTH-1:0]           shift;
  logic [$clog2(IQ_DEPTH)-1:0]   grant_idx;
  logic [$clog2(IQ_DEPTH)-1:0]   wr_idx;
  logic [$clog2(IQ_DEPTH):0]     count;

  //////////////////////////////////////////////////////////////
  // wakeup and oldest-ready select
  //////////////////////////////////////////////////////////////
  always_comb begin
    grant     = '0;
    shift     = '0;
    grant_idx = '0;
    count     = '0;
    for (int i = 0; i < IQ_DEPTH; i++) begin
      rdy_a_w[i] = rdy_a_q[i] || (cdb_valid && (cdb_tag == src_a_q[i]));
      rdy_b_w[i] = rdy_b_q[i] || (cdb_valid && (cdb_tag == src_b_q[i]));
      if (valid_q[i] && rdy_a_q[i] && rdy_b_q[i] && (grant == '0)) begin
        grant[i]  = 1'b1;
        grant_idx = ($clog2(IQ_DEPTH))'(i);
      end
      // granted entry and everything younger move down one slot
      shift[i] = |grant;
      count    = count + valid_q[i];
    end
  end

  assign iq_full     = valid_q[IQ_DEPTH-1];
  assign issue_valid = |grant;
  assign issue_op    = op_q[grant_idx];
  assign issue_src_a = src_a_q[grant_idx];
  assign issue_src_b = src_b_q[grant_idx];
  assign issue_imm   = imm_q[grant_idx];
  assign issue_dest  = dest_q[grant_idx];
  // new entry goes just above the survivors
  assign wr_idx      = ($clog2(IQ_DEPTH))'(count - issue_valid);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < IQ_DEPTH - 1; i++) begin
        if (shift[i]) begin
          valid_q[i] <= valid_q[i+1];
        end
      end
      if (shift[IQ_DEPTH-1]) begin
        valid_q[IQ_DEPTH-1] <= 1'b0;
      end
      if (alloc_fire) begin
        valid_q[wr_idx] <= 1'b1;
      end
    end
  end

  // payload and ready bits, meaningful only under valid_q
  always_ff @(posedge clock) begin
    rdy_a_q <= rdy_a_w;
    rdy_b_q <= rdy_b_w;
    for (int i = 0; i < IQ_DEPTH - 1; i++) begin
      if (shift[i]) begin
        op_q[i]    <= op_q[i+1];
        src_a_q[i] <= src_a_q[i+1];
        src_b_q[i] <= src_b_q[i+1];
        imm_q[i]   <= imm_q[i+1];
        dest_q[i]  <= dest_q[i+1];
        rdy_a_q[i] <= rdy_a_w[i+1];
        rdy_b_q[i] <= rdy_b_w[i+1];
      end
    end
    if (alloc_fire) begin
      op_q[wr_idx]    <= alloc_op;
      src_a_q[wr_idx] <= alloc_src_a;
      src_b_q[wr_idx] <= alloc_src_b;
      imm_q[wr_idx]   <= alloc_imm;
      dest_q[wr_idx]  <= alloc_new_tag;
      rdy_a_q[wr_idx] <= alloc_src_a_ready;
      rdy_b_q[wr_idx] <= alloc_src_b_ready;
    end
  end

  // live entries stay packed from slot 0 and no write lands while full
  assert property (@(posedge clock) disable iff (reset)
    ((valid_q & (valid_q + 1'b1)) == '0) && !(alloc_fire && iq_full));

endmodule

// ==== logic/phys_regfile.sv ====
`timescale 1ns/100ps
// physical register file
// A and B feed the ALU, R feeds the ROB head; all reads asynchronous
// one write port, driven by the CDB
module phys_regfile
  import ooo_pkg::*;
  import isa_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic [PHYS_REG_WIDTH-1:0] rd_a_tag,
  input  logic [PHYS_REG_WIDTH-1:0] rd_b_tag,
  input  logic [PHYS_REG_WIDTH-1:0] rd_r_tag,
  input  logic                      wr_en,
  input  logic [PHYS_REG_WIDTH-1:0] wr_tag,
  input  logic [DATA_WIDTH-1:0]     wr_data,
  output logic [DATA_WIDTH-1:0]     rd_a_data,
  output logic [DATA_WIDTH-1:0]     rd_b_data,
  output logic [DATA_WIDTH-1:0]     rd_r_data
);

  logic [DATA_WIDTH-1:0] regs [NUM_PHYS_REGS];

  assign rd_a_data = regs[rd_a_tag];
  assign rd_b_data = regs[rd_b_tag];
  assign rd_r_data = regs[rd_r_tag];

  // architectural state starts at zero
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_tag] <= wr_data;
    end
  end

endmodule

// ==== logic/execute_unit.sv ====
`timescale 1ns/100ps
// single-cycle ALU, its output register is the CDB
// one issue per cycle, no stall from downstream
module execute_unit
  import ooo_pkg::*;
  import isa_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      issue_valid,
  input  logic [OPCODE_WIDTH-1:0]   issue_op,
  input  logic [IMM_WIDTH-1:0]      issue_imm,
  input  logic [PHYS_REG_WIDTH-1:0] issue_dest,
  input  logic [DATA_WIDTH-1:0]     src_a_data,
  input  logic [DATA_WIDTH-1:0]     src_b_data,
  output logic                      cdb_valid,
  output logic [PHYS_REG_WIDTH-1:0] cdb_tag,
  output logic [DATA_WIDTH-1:0]     cdb_data
);

  logic [DATA_WIDTH-1:0] alu_result;

  // all ops wrap at 16 bits
  always_comb begin
    case (issue_op)
      OP_ADD:  alu_result = src_a_data + src_b_data;
      OP_SUB:  alu_result = src_a_data - src_b_data;
      OP_XOR:  alu_result = src_a_data ^ src_b_data;
      default: alu_result = {{(DATA_WIDTH - IMM_WIDTH){1'b0}}, issue_imm};
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= issue_valid;
    end
  end

  // broadcast payload
  always_ff @(posedge clock) begin
    if (issue_valid) begin
      cdb_tag  <= issue_dest;
      cdb_data <= alu_result;
    end
  end

endmodule

// ==== logic/ooo_core.sv ====
`timescale 1ns/100ps
// top of the renaming core, instances and wires only
// dispatch takes decoded words on valid/ready
// retire returns results in program order on valid/ready
// no flush path, every accepted instruction retires
module ooo_core
  import ooo_pkg::*;
  import isa_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      dispatch_valid,
  input  instr_u                    dispatch_instr,
  output logic                      dispatch_ready,
  output logic                      retire_valid,
  input  logic                      retire_ready,
  output logic [ARCH_REG_WIDTH-1:0] retire_arch_reg,
  output logic [DATA_WIDTH-1:0]     retire_value
);

  // rename to ROB and issue queue
  logic                      alloc_fire;
  logic [ARCH_REG_WIDTH-1:0] alloc_rd;
  logic [PHYS_REG_WIDTH-1:0] alloc_new_tag;
  logic [PHYS_REG_WIDTH-1:0] alloc_old_tag;
  logic [OPCODE_WIDTH-1:0]   alloc_op;
  logic [PHYS_REG_WIDTH-1:0] alloc_src_a;
  logic [PHYS_REG_WIDTH-1:0] alloc_src_b;
  logic                      alloc_src_a_ready;
  logic                      alloc_src_b_ready;
  logic [IMM_WIDTH-1:0]      alloc_imm;
  logic                      rob_full;
  logic                      iq_full;
  // ROB back to rename and the register file
  logic                      free_valid;
  logic [PHYS_REG_WIDTH-1:0] free_tag;
  logic [PHYS_REG_WIDTH-1:0] head_tag;
  logic [DATA_WIDTH-1:0]     head_value;
  // issue and operand read
  logic                      issue_valid;
  logic [OPCODE_WIDTH-1:0]   issue_op;
  logic [PHYS_REG_WIDTH-1:0] issue_src_a;
  logic [PHYS_REG_WIDTH-1:0] issue_src_b;
  logic [IMM_WIDTH-1:0]      issue_imm;
  logic [PHYS_REG_WIDTH-1:0] issue_dest;
  logic [DATA_WIDTH-1:0]     src_a_data;
  logic [DATA_WIDTH-1:0]     src_b_data;
  // common data bus
  logic                      cdb_valid;
  logic [PHYS_REG_WIDTH-1:0] cdb_tag;
  logic [DATA_WIDTH-1:0]     cdb_data;

  //////////////////////////////////////////////////////////////
  // pipeline blocks, ports named after the wires above
  //////////////////////////////////////////////////////////////
  rename_stage   rename_stage_inst   (.*);
  reorder_buffer reorder_buffer_inst (.*);
  issue_queue    issue_queue_inst    (.*);
  execute_unit   execute_unit_inst   (.*);

  // CDB writes, issue and ROB head read
  phys_regfile phys_regfile_inst (
    .clock     (clock),
    .reset     (reset),
    .rd_a_tag  (issue_src_a),
    .rd_b_tag  (issue_src_b),
    .rd_r_tag  (head_tag),
    .wr_en     (cdb_valid),
    .wr_tag    (cdb_tag),
    .wr_data   (cdb_data),
    .rd_a_data (src_a_data),
    .rd_b_data (src_b_data),
    .rd_r_data (head_value)
  );

endmodule

// ==== sim/ooo_core_tb.sv ====
`timescale 1ns/100ps
// testbench for the renaming core
// a table of decoded instructions with hand-computed results feeds dispatch
// while a checker follows the retire port in program order
// register state carries over from one test to the next
// retire_ready follows a per-test pattern: open, held, throttled or random
module ooo_core_tb
  import ooo_pkg::*;
  import isa_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 200;
  // retire_ready patterns
  localparam int MODE_OPEN     = 0;
  localparam int MODE_HOLD     = 1;
  localparam int MODE_THROTTLE = 2;
  localparam int MODE_RANDOM   = 3;

  logic                      clock;
  logic                      reset;
  logic                      dispatch_valid;
  instr_u                    dispatch_instr;
  logic                      dispatch_ready;
  logic                      retire_valid;
  logic                      retire_ready;
  logic [ARCH_REG_WIDTH-1:0] retire_arch_reg;
  logic [DATA_WIDTH-1:0]     retire_value;

  // stimulus table, one row per instruction
  instr_u                    row_instr [$];
  logic [ARCH_REG_WIDTH-1:0] row_rd    [$];
  logic [DATA_WIDTH-1:0]     row_value [$];
  string                     test_name  [$];
  int                        test_mode  [$];
  int                        test_first [$];

  int     checks;
  int     errors;
  int     retired;
  bit     abort;
  bit     stall_seen;
  integer seed;

  ooo_core ooo_core_inst (
    .clock           (clock),
    .reset           (reset),
    .dispatch_valid  (dispatch_valid),
    .dispatch_instr  (dispatch_instr),
    .dispatch_ready  (dispatch_ready),
    .retire_valid    (retire_valid),
    .retire_ready    (retire_ready),
    .retire_arch_reg (retire_arch_reg),
    .retire_value    (retire_value)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////
  // table building
  //////////////////////////////////////////////////////////////
  function automatic instr_u encode_reg(input logic [OPCODE_WIDTH-1:0] op,
                                        input int rd, input int ra, input int rb);
    instr_u w;
    w = '0;
    w.r.opcode = op;
    w.r.rd     = ARCH_REG_WIDTH'(rd);
    w.r.ra     = ARCH_REG_WIDTH'(ra);
    w.r.rb     = ARCH_REG_WIDTH'(rb);
    return w;
  endfunction

  function automatic instr_u encode_imm(input int rd, input int imm);
    instr_u w;
    w = '0;
    w.i.opcode = OP_LI;
    w.i.rd     = ARCH_REG_WIDTH'(rd);
    w.i.imm    = IMM_WIDTH'(imm);
    return w;
  endfunction

  task automatic add_row(input instr_u instr, input int rd, input logic [DATA_WIDTH-1:0] value);
    row_instr.push_back(instr);
    row_rd.push_back(ARCH_REG_WIDTH'(rd));
    row_value.push_back(value);
  endtask

  task automatic start_test(input string name, input int mode);
    test_name.push_back(name);
    test_mode.push_back(mode);
    test_first.push_back(row_instr.size());
  endtask

  function automatic int rows_in_test(input int t);
    if (t + 1 < test_first.size()) return test_first[t+1] - test_first[t];
    return row_instr.size() - test_first[t];
  endfunction

  // expected values follow program order, state kept from earlier tests
  task automatic load_program();
    start_test("li series", MODE_OPEN);
    add_row(encode_imm(1, 'h7FF), 1, 16'h07FF);
    add_row(encode_imm(2, 'h123), 2, 16'h0123);
    add_row(encode_imm(3, 'h001), 3, 16'h0001);
    add_row(encode_imm(4, 'h555), 4, 16'h0555);
    add_row(encode_imm(5, 'h000), 5, 16'h0000);
    add_row(encode_imm(6, 'h2AA), 6, 16'h02AA);
    // doubling chain on r7, wraps past 16 bits on the r2 add
    start_test("dependent chain", MODE_OPEN);
    add_row(encode_reg(OP_ADD, 7, 1, 1), 7, 16'h0FFE);
    add_row(encode_reg(OP_ADD, 7, 7, 7), 7, 16'h1FFC);
    add_row(encode_reg(OP_ADD, 7, 7, 7), 7, 16'h3FF8);
    add_row(encode_reg(OP_ADD, 7, 7, 7), 7, 16'h7FF0);
    add_row(encode_reg(OP_ADD, 7, 7, 7), 7, 16'hFFE0);
    add_row(encode_reg(OP_ADD, 7, 7, 2), 7, 16'h0103);
    add_row(encode_reg(OP_SUB, 5, 3, 2), 5, 16'hFEDE);
    add_row(encode_reg(OP_XOR, 6, 5, 4), 6, 16'hFB8B);
    add_row(encode_reg(OP_SUB, 0, 6, 7), 0, 16'hFA88);
    add_row(encode_reg(OP_ADD, 1, 0, 5), 1, 16'hF966);
    // sixteen writes to r2, twice the free list
    start_test("free list wrap", MODE_THROTTLE);
    add_row(encode_imm(2, 'h001), 2, 16'h0001);
    add_row(encode_reg(OP_ADD, 2, 2, 2), 2, 16'h0002);
    add_row(encode_imm(2, 'h7FF), 2, 16'h07FF);
    add_row(encode_reg(OP_ADD, 2, 2, 2), 2, 16'h0FFE);
    add_row(encode_imm(2, 'h400), 2, 16'h0400);
    add_row(encode_reg(OP_ADD, 2, 2, 2), 2, 16'h0800);
    add_row(encode_imm(2, 'h0AB), 2, 16'h00AB);
    add_row(encode_reg(OP_ADD, 2, 2, 2), 2, 16'h0156);
    add_row(encode_imm(2, 'h3C3), 2, 16'h03C3);
    add_row(encode_reg(OP_ADD, 2, 2, 2), 2, 16'h0786);
    add_row(encode_imm(2, 'h100), 2, 16'h0100);
    add_row(encode_reg(OP_ADD, 2, 2, 2), 2, 16'h0200);
    add_row(encode_imm(2, 'h555), 2, 16'h0555);
    add_row(encode_reg(OP_ADD, 2, 2, 2), 2, 16'h0AAA);
    add_row(encode_imm(2, 'h010), 2, 16'h0010);
    add_row(encode_reg(OP_ADD, 2, 2, 2), 2, 16'h0020);
    // more rows than the ROB holds
    start_test("rob fill", MODE_HOLD);
    add_row(encode_reg(OP_XOR, 3, 3, 4), 3, 16'h0554);
    add_row(encode_reg(OP_ADD, 4, 4, 2), 4, 16'h0575);
    add_row(encode_imm(5, 'h0FF), 5, 16'h00FF);
    add_row(encode_reg(OP_SUB, 6, 5, 3), 6, 16'hFBAB);
    add_row(encode_reg(OP_ADD, 7, 7, 7), 7, 16'h0206);
    add_row(encode_reg(OP_XOR, 0, 0, 1), 0, 16'h03EE);
    add_row(encode_imm(1, 'h6D2), 1, 16'h06D2);
    add_row(encode_reg(OP_ADD, 2, 1, 0), 2, 16'h0AC0);
    add_row(encode_reg(OP_SUB, 3, 2, 4), 3, 16'h054B);
    add_row(encode_reg(OP_XOR, 4, 6, 7), 4, 16'hF9AD);
    add_row(encode_reg(OP_ADD, 5, 5, 5), 5, 16'h01FE);
    add_row(encode_reg(OP_SUB, 0, 0, 0), 0, 16'h0000);
    start_test("random retire", MODE_RANDOM);
    add_row(encode_imm(0, 'h7FF), 0, 16'h07FF);
    add_row(encode_reg(OP_ADD, 1, 0, 4), 1, 16'h01AC);
    add_row(encode_reg(OP_SUB, 2, 0, 1), 2, 16'h0653);
    add_row(encode_reg(OP_XOR, 3, 2, 6), 3, 16'hFDF8);
    add_row(encode_reg(OP_ADD, 4, 3, 3), 4, 16'hFBF0);
    add_row(encode_reg(OP_SUB, 5, 5, 4), 5, 16'h060E);
    add_row(encode_imm(6, 'h001), 6, 16'h0001);
    add_row(encode_reg(OP_SUB, 7, 6, 7), 7, 16'hFDFB);
    add_row(encode_reg(OP_XOR, 0, 7, 5), 0, 16'hFBF5);
    add_row(encode_reg(OP_ADD, 1, 1, 2), 1, 16'h07FF);
    add_row(encode_reg(OP_XOR, 2, 2, 2), 2, 16'h0000);
    add_row(encode_reg(OP_ADD, 3, 0, 1), 3, 16'h03F4);
  endtask

  //////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////
  task automatic check_arch_reg(input string name, input logic [ARCH_REG_WIDTH-1:0] got,
                                input logic [ARCH_REG_WIDTH-1:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
    end
  endtask

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // dispatch and retire loops
  //////////////////////////////////////////////////////////////
  // held mode opens only once dispatch has been seen stalling
  function automatic logic pick_ready(input int mode, input int cycle);
    case (mode)
      MODE_HOLD:     return stall_seen;
      MODE_THROTTLE: return (cycle % 4) == 0;
      MODE_RANDOM:   return 1'($random(seed));
      default:       return 1'b1;
    endcase
  endfunction

  task automatic dispatch_rows(input int first, input int count);
    int waited;
    bit accepted;
    for (int r = first; r < first + count; r++) begin
      if (abort) break;
      dispatch_valid <= 1'b1;
      dispatch_instr <= row_instr[r];
      accepted = 1'b0;
      waited   = 0;
      while (!accepted && !abort) begin
        @(posedge clock);
        accepted = dispatch_ready;
        waited++;
        if (!accepted && waited >= TIMEOUT_CYCLES) begin
          $display("timeout: dispatch_ready stayed low for %0d cycles on row %0d",
                   TIMEOUT_CYCLES, r);
          errors++;
          abort = 1'b1;
        end
      end
    end
    dispatch_valid <= 1'b0;
  endtask

  task automatic retire_rows(input int first, input int count, input int mode);
    int waited;
    int cycle;
    bit fire;
    cycle = 0;
    retire_ready <= pick_ready(mode, cycle);
    for (int r = first; r < first + count; r++) begin
      fire   = 1'b0;
      waited = 0;
      while (!fire && !abort) begin
        @(posedge clock);
        cycle++;
        waited++;
        // stall seen here too, from values sampled at the edge
        if (dispatch_valid && !dispatch_ready) stall_seen = 1'b1;
        fire = retire_valid && retire_ready;
        if (fire) begin
          check_arch_reg("retire_arch_reg", retire_arch_reg, row_rd[r]);
          check_value("retire_value", retire_value, row_value[r]);
          retired++;
        end else if (waited >= TIMEOUT_CYCLES) begin
          $display("timeout: no result retired within %0d cycles for row %0d",
                   TIMEOUT_CYCLES, r);
          errors++;
          abort = 1'b1;
        end
        retire_ready <= pick_ready(mode, cycle);
      end
    end
    retire_ready <= 1'b0;
  endtask

  task automatic report_test(input int num, input string name, input int results,
                             input int errors_before);
    $display("test %0d (%s): %s, %0d results checked", num, name,
             (errors == errors_before) ? "ok" : "FAILED", results);
  endtask

  //////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////
  initial begin
    int n;
    int errors_before;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_instr = '0;
    retire_ready   = 1'b0;
    checks         = 0;
    errors         = 0;
    retired        = 0;
    abort          = 1'b0;
    stall_seen     = 1'b0;
    seed           = 32'h2379;
    load_program();
    repeat (3) @(posedge clock);
    reset <= 1'b0;

    // first cycle out of reset
    @(posedge clock);
    errors_before = errors;
    check_flag("retire_valid", retire_valid, 1'b0);
    check_flag("dispatch_ready", dispatch_ready, 1'b1);
    report_test(1, "reset state", 0, errors_before);

    for (int t = 0; t < test_name.size() && !abort; t++) begin
      n             = rows_in_test(t);
      errors_before = errors;
      stall_seen    = 1'b0;
      retired       = 0;
      fork
        dispatch_rows(test_first[t], n);
        retire_rows(test_first[t], n, test_mode[t]);
      join
      if (!abort) begin
        // ROB drained, nothing left to repeat
        @(posedge clock);
        check_flag("retire_valid", retire_valid, 1'b0);
        if ((test_mode[t] == MODE_HOLD || test_mode[t] == MODE_THROTTLE) && !stall_seen) begin
          $display("dispatch_ready never dropped during test %0d", t + 2);
          errors++;
        end
      end
      report_test(t + 2, test_name[t], retired, errors_before);
    end

    $display("tests %0d, checks %0d, errors %0d", test_name.size() + 1, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
common/ooo_pkg.sv
common/isa_pkg.sv
rename/free_list.sv
rename/rename_stage.sv
rob/reorder_buffer.sv
logic/issue_queue.sv
logic/phys_regfile.sv
logic/execute_unit.sv
logic/ooo_core.sv
sim/ooo_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the renaming core testbench
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps -j 0
PASS_TEXT ?= Simulation finished: PASS

.PHONY: sim clean

# fails unless the pass line shows up in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
